// File: Makefile
TOP := tb_ilk_tx_lane_path

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f ilk_tx_lane_path.f \
		--top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

lint:
	verilator --lint-only -Wall --top-module ilk_tx_lane_path \
		hdl/ilk_tx_pkg.sv hdl/ilk_tx_ingress.sv hdl/ilk_tx_fifo.sv \
		hdl/ilk_tx_aligner.sv hdl/ilk_tx_lane_path.sv

clean:
	rm -rf obj_dir sim.log

// File: hdl/ilk_tx_aligner.sv
// Transmit aligner and frame generator
// waits for the FIFO to fill past the partly-empty level,
// then drives all lanes together; a sync word opens every
// metaframe and idle words fill in when the FIFO runs dry

`timescale 1ns/1ps
`default_nettype none

module ilk_tx_aligner
    import ilk_tx_pkg::*;
(
    input  wire          clk_tx_common,
    input  wire          arst_n,

    // FIFO read side
    input  wire          rd_valid,
    input  bundle_data_t rd_data,
    input  bundle_ctl_t  rd_ctl,
    input  wire          fifo_pempty,
    output logic         rd_ready,

    // status
    output logic         tx_lanes_aligned,

    // lane output
    output logic         lane_valid,
    output bundle_data_t lane_dout,
    output bundle_ctl_t  lane_control,
    input  wire          lane_ready
);

    txa_state_t   state;
    meta_pos_t    meta_pos;
    meta_pos_t    next_pos;
    logic         enter_aligned;
    logic         load_word;
    bundle_data_t word_data;
    bundle_ctl_t  word_ctl;

    ////////////////////////////////////////
    // fill state machine
    ////////////////////////////////////////
    assign enter_aligned = (state == TXA_FILL) & ~fifo_pempty;

    always_ff @(posedge clk_tx_common or negedge arst_n) begin
        if (!arst_n) begin
            state <= TXA_FILL;
        end else if (enter_aligned) begin
            // no way back short of reset
            state <= TXA_ALIGNED;
        end
    end

    assign tx_lanes_aligned = (state == TXA_ALIGNED);
    assign lane_valid       = (state == TXA_ALIGNED);

    // next word loads as the current one is taken
    assign load_word = lane_valid & lane_ready;

    ////////////////////////////////////////
    // metaframe position
    ////////////////////////////////////////
    // meta_pos is the position of the word in the output register
    assign next_pos = (meta_pos == meta_pos_t'(METALEN - 1)) ? '0 : meta_pos + 1'b1;

    always_ff @(posedge clk_tx_common or negedge arst_n) begin
        if (!arst_n) begin
            meta_pos <= '0;
        end else if (load_word) begin
            meta_pos <= next_pos;
        end
    end

    // pop only for a data slot and never for the sync slot
    assign rd_ready = load_word & (next_pos != '0);

    ////////////////////////////////////////
    // word select
    ////////////////////////////////////////
    always_comb begin
        if ((state == TXA_FILL) || (next_pos == '0)) begin
            // first word after alignment is position 0 too
            word_data = {NUM_LANES{SYNC_WORD}};
            word_ctl  = '1;
        end else if (rd_valid) begin
            word_data = rd_data;
            word_ctl  = rd_ctl;
        end else begin
            // force fill when the FIFO ran dry
            word_data = {NUM_LANES{IDLE_WORD}};
            word_ctl  = '1;
        end
    end

    ////////////////////////////////////////
    // lane output registers
    ////////////////////////////////////////
    always_ff @(posedge clk_tx_common) begin
        if (enter_aligned || load_word) begin
            lane_dout    <= word_data;
            lane_control <= word_ctl;
        end
    end

endmodule

`default_nettype wire

// File: hdl/ilk_tx_fifo.sv
// Transmit lane-bundle FIFO
// all lanes share one clock and are written in lockstep,
// so one FIFO stores whole bundles; keeps a fill count and
// registered programmable-full and programmable-empty flags

`timescale 1ns/1ps
`default_nettype none

module ilk_tx_fifo
    import ilk_tx_pkg::*;
(
    input  wire          clk_tx_common,
    input  wire          arst_n,

    // write side
    input  wire          wr_valid,
    input  bundle_data_t wr_data,
    input  bundle_ctl_t  wr_ctl,
    output logic         wr_ready,

    // read side
    output logic         rd_valid,
    output bundle_data_t rd_data,
    output bundle_ctl_t  rd_ctl,
    input  wire          rd_ready,

    // level flags
    output logic         fifo_pempty,
    output logic         fifo_pfull
);

    bundle_data_t     data_mem [FIFO_DEPTH];
    bundle_ctl_t      ctl_mem  [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    fifo_cnt_t        cnt;
    fifo_cnt_t        cnt_nxt;
    logic             wr_fire;
    logic             rd_fire;

    assign wr_ready = (cnt < fifo_cnt_t'(FIFO_DEPTH));
    assign rd_valid = (cnt != '0);
    assign wr_fire  = wr_valid & wr_ready;
    assign rd_fire  = rd_valid & rd_ready;

    // head entry always on the read port
    assign rd_data  = data_mem[rd_ptr];
    assign rd_ctl   = ctl_mem[rd_ptr];

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////
    always_ff @(posedge clk_tx_common) begin
        if (wr_fire) begin
            data_mem[wr_ptr] <= wr_data;
            ctl_mem[wr_ptr]  <= wr_ctl;
        end
    end

    // count after this cycle's push and pop
    always_comb begin
        cnt_nxt = cnt;
        case ({wr_fire, rd_fire})
            2'b10:   cnt_nxt = cnt + 1'b1;
            2'b01:   cnt_nxt = cnt - 1'b1;
            default: cnt_nxt = cnt;
        endcase
    end

    ////////////////////////////////////////
    // pointers, count and flags
    ////////////////////////////////////////
    always_ff @(posedge clk_tx_common or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            cnt         <= '0;
            fifo_pempty <= 1'b1;
            fifo_pfull  <= 1'b0;
        end else begin
            // pointers wrap at FIFO_DEPTH by width
            if (wr_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            cnt         <= cnt_nxt;
            fifo_pempty <= (cnt_nxt < fifo_cnt_t'(PEMPTY_LEVEL));
            fifo_pfull  <= (cnt_nxt >= fifo_cnt_t'(PFULL_LEVEL));
        end
    end

endmodule

`default_nettype wire

// File: hdl/ilk_tx_ingress.sv
// Transmit ingress stage
// holds one lane bundle from the user side and drives it
// toward the FIFO; tx_cadence tells the user when a word
// is taken

`timescale 1ns/1ps
`default_nettype none

module ilk_tx_ingress
    import ilk_tx_pkg::*;
(
    input  wire          clk_tx_common,
    input  wire          arst_n,

    // user side
    input  bundle_data_t tx_din,
    input  bundle_ctl_t  tx_control,
    input  wire          tx_valid,
    output logic         tx_cadence,

    // FIFO write side
    output logic         wr_valid,
    output bundle_data_t wr_data,
    output bundle_ctl_t  wr_ctl,
    input  wire          wr_ready
);

    logic accept;

    // stage can take a word when empty or draining this cycle
    assign tx_cadence = ~wr_valid | wr_ready;
    assign accept     = tx_valid & tx_cadence;

    ////////////////////////////////////////
    // stage occupancy
    ////////////////////////////////////////
    always_ff @(posedge clk_tx_common or negedge arst_n) begin
        if (!arst_n) begin
            wr_valid <= 1'b0;
        end else if (accept) begin
            wr_valid <= 1'b1;
        end else if (wr_ready) begin
            // word went into the FIFO, nothing new behind it
            wr_valid <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // bundle payload
    ////////////////////////////////////////
    // only loaded on accept, so it holds under back-pressure
    always_ff @(posedge clk_tx_common) begin
        if (accept) begin
            wr_data <= tx_din;
            wr_ctl  <= tx_control;
        end
    end

endmodule

`default_nettype wire

// File: hdl/ilk_tx_lane_path.sv
// Interlaken-style transmit lane path, top level
// user word interface into a register stage, a lockstep
// lane-bundle FIFO, then the aligner and frame generator
// toward the serializer

`timescale 1ns/1ps
`default_nettype none

module ilk_tx_lane_path
    import ilk_tx_pkg::*;
(
    input  wire          clk_tx_common,
    input  wire          arst_n,

    // user side
    input  bundle_data_t tx_din,
    input  bundle_ctl_t  tx_control,
    input  wire          tx_valid,
    output logic         tx_cadence,

    // status
    output logic         tx_lanes_aligned,
    output logic         tx_pcsfifo_pfull,
    output logic         tx_pcsfifo_pempty,

    // serializer side
    output logic         lane_valid,
    output bundle_data_t lane_dout,
    output bundle_ctl_t  lane_control,
    input  wire          lane_ready
);

    // ingress to FIFO
    logic         wr_valid;
    logic         wr_ready;
    bundle_data_t wr_data;
    bundle_ctl_t  wr_ctl;

    // FIFO to aligner
    logic         rd_valid;
    logic         rd_ready;
    bundle_data_t rd_data;
    bundle_ctl_t  rd_ctl;

    ilk_tx_ingress ingress_inst (
        .clk_tx_common ( clk_tx_common ),
        .arst_n        ( arst_n ),
        .tx_din        ( tx_din ),
        .tx_control    ( tx_control ),
        .tx_valid      ( tx_valid ),
        .tx_cadence    ( tx_cadence ),
        .wr_valid      ( wr_valid ),
        .wr_data       ( wr_data ),
        .wr_ctl        ( wr_ctl ),
        .wr_ready      ( wr_ready )
    );

    // FIFO flags are the top-level status flags
    ilk_tx_fifo fifo_inst (
        .clk_tx_common ( clk_tx_common ),
        .arst_n        ( arst_n ),
        .wr_valid      ( wr_valid ),
        .wr_data       ( wr_data ),
        .wr_ctl        ( wr_ctl ),
        .wr_ready      ( wr_ready ),
        .rd_valid      ( rd_valid ),
        .rd_data       ( rd_data ),
        .rd_ctl        ( rd_ctl ),
        .rd_ready      ( rd_ready ),
        .fifo_pempty   ( tx_pcsfifo_pempty ),
        .fifo_pfull    ( tx_pcsfifo_pfull )
    );

    ilk_tx_aligner aligner_inst (
        .clk_tx_common    ( clk_tx_common ),
        .arst_n           ( arst_n ),
        .rd_valid         ( rd_valid ),
        .rd_data          ( rd_data ),
        .rd_ctl           ( rd_ctl ),
        .fifo_pempty      ( tx_pcsfifo_pempty ),
        .rd_ready         ( rd_ready ),
        .tx_lanes_aligned ( tx_lanes_aligned ),
        .lane_valid       ( lane_valid ),
        .lane_dout        ( lane_dout ),
        .lane_control     ( lane_control ),
        .lane_ready       ( lane_ready )
    );

endmodule

`default_nettype wire

// File: hdl/ilk_tx_pkg.sv
// Interlaken-style transmit lane path, shared definitions
// lane count, word widths, FIFO levels, metaframe length,
// inserted control words and the aligner state encoding

`default_nettype none

package ilk_tx_pkg;

    ////////////////////////////////////////
    // sizes and levels
    ////////////////////////////////////////
    localparam int NUM_LANES    = 4;
    localparam int WORD_W       = 64;
    localparam int FIFO_DEPTH   = 16;
    localparam int PTR_W        = $clog2(FIFO_DEPTH);
    localparam int CNT_W        = 5;
    // below this the FIFO is partly empty
    localparam int PEMPTY_LEVEL = 8;
    // at or above this the FIFO is partly full
    localparam int PFULL_LEVEL  = 12;
    // output words per metaframe, sync word included
    localparam int METALEN      = 64;

    ////////////////////////////////////////
    // types
    ////////////////////////////////////////
    typedef logic [WORD_W-1:0]           lane_word_t;
    typedef logic [NUM_LANES*WORD_W-1:0] bundle_data_t;
    typedef logic [NUM_LANES-1:0]        bundle_ctl_t;
    typedef logic [CNT_W-1:0]            fifo_cnt_t;
    typedef logic [5:0]                  meta_pos_t;

    typedef enum logic [0:0] {
        TXA_FILL,
        TXA_ALIGNED
    } txa_state_t;

    ////////////////////////////////////////
    // inserted words, control bit set
    ////////////////////////////////////////
    // framing layer sync pattern
    localparam lane_word_t SYNC_WORD = 64'h78f6_78f6_78f6_78f6;
    // idle control word used for force fill
    localparam lane_word_t IDLE_WORD = 64'h8000_0000_0000_0007;

endpackage

`default_nettype wire

// File: ilk_tx_lane_path.f
hdl/ilk_tx_pkg.sv
hdl/ilk_tx_ingress.sv
hdl/ilk_tx_fifo.sv
hdl/ilk_tx_aligner.sv
hdl/ilk_tx_lane_path.sv
test/tb_clk_gen.sv
test/ilk_tx_lane_path_chk.sv
test/tb_ilk_tx_lane_path.sv

// File: test/ilk_tx_lane_path_chk.sv
// Lane path checker bound into the top level
// keeps a queue of accepted user bundles as the reference and
// checks reset values, fill before alignment, data order,
// metaframe sync, idle fill and back-pressure

`timescale 1ns/1ps
`default_nettype none

module ilk_tx_lane_path_chk
    import ilk_tx_pkg::*;
(
    input wire          clk_tx_common,
    input wire          arst_n,
    input bundle_data_t tx_din,
    input bundle_ctl_t  tx_control,
    input wire          tx_valid,
    input wire          tx_cadence,
    input wire          tx_lanes_aligned,
    input wire          tx_pcsfifo_pfull,
    input wire          tx_pcsfifo_pempty,
    input wire          lane_valid,
    input bundle_data_t lane_dout,
    input bundle_ctl_t  lane_control,
    input wire          lane_ready
);

    localparam bundle_data_t SYNC_ALL = {NUM_LANES{SYNC_WORD}};
    localparam bundle_data_t IDLE_ALL = {NUM_LANES{IDLE_WORD}};
    localparam bundle_ctl_t  CTL_ALL  = '1;

    bundle_data_t data_q [$];
    bundle_ctl_t  ctl_q [$];
    bundle_data_t head_data;
    bundle_ctl_t  head_ctl;
    logic         head_valid;
    int           q_size;
    int           held_words;
    int           acc_cnt;
    int           out_pos;
    int           fail_cnt = 0;
    logic         in_fire;
    logic         out_fire;
    logic         data_word;

    assign in_fire   = tx_valid & tx_cadence;
    assign out_fire  = lane_valid & lane_ready;
    // inserted words carry control on all lanes and user words never do
    assign data_word = out_fire & (lane_control != '1);
    // words in the ingress stage and the FIFO
    assign held_words = q_size - ((lane_valid && lane_control != '1) ? 1 : 0);

    ////////////////////////////////////////
    // reference queue
    ////////////////////////////////////////
    always @(posedge clk_tx_common or negedge arst_n) begin
        if (!arst_n) begin
            data_q.delete();
            ctl_q.delete();
            acc_cnt <= 0;
            out_pos <= 0;
        end else begin
            if (data_word && data_q.size() != 0) begin
                void'(data_q.pop_front());
                void'(ctl_q.pop_front());
            end
            if (in_fire) begin
                data_q.push_back(tx_din);
                ctl_q.push_back(tx_control);
                acc_cnt <= acc_cnt + 1;
            end
            // position of the next output word in its metaframe
            if (out_fire) begin
                out_pos <= (out_pos == METALEN - 1) ? 0 : out_pos + 1;
            end
        end
        q_size     <= data_q.size();
        head_valid <= (data_q.size() != 0);
        head_data  <= (data_q.size() != 0) ? data_q[0] : '0;
        head_ctl   <= (data_q.size() != 0) ? ctl_q[0] : '0;
    end

    ////////////////////////////////////////
    // assertions
    ////////////////////////////////////////
    a_reset_state: assert property (@(posedge clk_tx_common)
        (!arst_n || $rose(arst_n)) |-> (!tx_lanes_aligned && !lane_valid
            && !tx_pcsfifo_pfull && tx_pcsfifo_pempty && tx_cadence))
    else begin
        fail_cnt++;
        $error("** Error %0t aligned/valid/pfull/pempty/cadence got %b%b%b%b%b exp 00011",
               $time, $sampled(tx_lanes_aligned), $sampled(lane_valid),
               $sampled(tx_pcsfifo_pfull), $sampled(tx_pcsfifo_pempty), $sampled(tx_cadence));
    end

    a_fill_first: assert property (@(posedge clk_tx_common) disable iff (!arst_n)
        $rose(tx_lanes_aligned) |-> acc_cnt >= PEMPTY_LEVEL)
    else begin
        fail_cnt++;
        $error("lanes aligned after only %0d accepted bundles", $sampled(acc_cnt));
    end

    a_aligned_stays: assert property (@(posedge clk_tx_common) disable iff (!arst_n)
        tx_lanes_aligned |=> tx_lanes_aligned)
    else begin
        fail_cnt++;
        $error("tx_lanes_aligned fell without a reset");
    end

    a_valid_aligned: assert property (@(posedge clk_tx_common) disable iff (!arst_n)
        tx_lanes_aligned |-> lane_valid)
    else begin
        fail_cnt++;
        $error("** Error %0t lane_valid got 0 exp 1 with lanes aligned", $time);
    end

    a_no_extra_word: assert property (@(posedge clk_tx_common) disable iff (!arst_n)
        data_word |-> head_valid)
    else begin
        fail_cnt++;
        $error("data word sent that the user never gave");
    end

    a_data_order: assert property (@(posedge clk_tx_common) disable iff (!arst_n)
        (data_word && head_valid) |-> (lane_dout == head_data && lane_control == head_ctl))
    else begin
        fail_cnt++;
        $error("** Error %0t lane_dout got %h exp %h, lane_control got %b exp %b", $time,
               $sampled(lane_dout), $sampled(head_data),
               $sampled(lane_control), $sampled(head_ctl));
    end

    a_sync_word: assert property (@(posedge clk_tx_common) disable iff (!arst_n)
        (out_fire && out_pos == 0) |-> (lane_control == '1 && lane_dout == SYNC_ALL))
    else begin
        fail_cnt++;
        $error("** Error %0t sync slot lane_dout got %h exp %h, lane_control got %b exp %b",
               $time, $sampled(lane_dout), SYNC_ALL, $sampled(lane_control), CTL_ALL);
    end

    a_idle_word: assert property (@(posedge clk_tx_common) disable iff (!arst_n)
        (out_fire && out_pos != 0 && lane_control == '1) |-> lane_dout == IDLE_ALL)
    else begin
        fail_cnt++;
        $error("** Error %0t idle slot lane_dout got %h exp %h",
               $time, $sampled(lane_dout), IDLE_ALL);
    end

    a_hold_stable: assert property (@(posedge clk_tx_common) disable iff (!arst_n)
        (lane_valid && !lane_ready) |=> ($stable(lane_dout) && $stable(lane_control)))
    else begin
        fail_cnt++;
        $error("lane output changed while lane_ready was low");
    end

    // stage and FIFO both full
    a_full_stall: assert property (@(posedge clk_tx_common) disable iff (!arst_n)
        held_words > FIFO_DEPTH |-> (tx_pcsfifo_pfull && !tx_cadence))
    else begin
        fail_cnt++;
        $error("** Error %0t with %0d words held pfull got %b exp 1, cadence got %b exp 0",
               $time, $sampled(held_words), $sampled(tx_pcsfifo_pfull), $sampled(tx_cadence));
    end

endmodule

bind ilk_tx_lane_path ilk_tx_lane_path_chk chk (.*);

`default_nettype wire

// File: test/tb_clk_gen.sv
// Testbench clock and reset source
// 4 ns clock, active-low reset held for four rising edges

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic arst_n
);

    localparam real HALF_PERIOD  = 2.0;
    localparam int  RESET_CYCLES = 4;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // real falling edge so the asynchronous reset fires before the first clock
    initial begin
        arst_n = 1'b1;
        #1 arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: test/tb_ilk_tx_lane_path.sv
// Testbench top for the transmit lane path
// drives random lane bundles through reset, fill, idle and
// back-pressure phases; the bound checker does the checking

`timescale 1ns/1ps
`default_nettype none

module tb_ilk_tx_lane_path
    import ilk_tx_pkg::*;
();

    localparam int NUM_PHASES     = 4;
    localparam int TIMEOUT_CYCLES = 4 * METALEN * NUM_PHASES + 200;

    logic         clk_tx_common;
    logic         arst_n;
    bundle_data_t tx_din;
    bundle_ctl_t  tx_control;
    logic         tx_valid;
    logic         lane_ready;
    logic         tx_cadence;
    logic         tx_lanes_aligned;
    logic         tx_pcsfifo_pfull;
    logic         tx_pcsfifo_pempty;
    logic         lane_valid;
    bundle_data_t lane_dout;
    bundle_ctl_t  lane_control;
    int           seed = 32'h4be8_d01c;
    int           cycle_cnt = 0;
    int           phase_cnt = 0;

    tb_clk_gen clk_gen_inst (
        .clk    ( clk_tx_common ),
        .arst_n ( arst_n )
    );

    ilk_tx_lane_path DUT (
        .clk_tx_common     ( clk_tx_common ),
        .arst_n            ( arst_n ),
        .tx_din            ( tx_din ),
        .tx_control        ( tx_control ),
        .tx_valid          ( tx_valid ),
        .tx_cadence        ( tx_cadence ),
        .tx_lanes_aligned  ( tx_lanes_aligned ),
        .tx_pcsfifo_pfull  ( tx_pcsfifo_pfull ),
        .tx_pcsfifo_pempty ( tx_pcsfifo_pempty ),
        .lane_valid        ( lane_valid ),
        .lane_dout         ( lane_dout ),
        .lane_control      ( lane_control ),
        .lane_ready        ( lane_ready )
    );

    // random bundle, control never set on every lane
    task automatic load_random_bundle;
        bundle_data_t d;
        bundle_ctl_t  c;
        for (int i = 0; i < NUM_LANES * WORD_W / 32; i++) begin
            d[i*32 +: 32] = $random(seed);
        end
        c = bundle_ctl_t'($random(seed));
        if (c == '1) begin
            c[0] = 1'b0;
        end
        tx_din     <= d;
        tx_control <= c;
    endtask

    // one call per rising edge; a pending word is held until taken
    task automatic run_cycles(input int n, input logic send, input logic ready);
        for (int k = 0; k < n; k++) begin
            @(posedge clk_tx_common);
            lane_ready <= ready;
            if (!tx_valid || tx_cadence) begin
                if (send) begin
                    load_random_bundle();
                end
                tx_valid <= send;
            end
        end
    endtask

    task automatic report_phase(input string name);
        phase_cnt++;
        $display("test %0d %s done at %0t, assertion failures so far %0d",
                 phase_cnt, name, $time, DUT.chk.fail_cnt);
    endtask

    initial begin
        tx_din     = '0;
        tx_control = '0;
        tx_valid   = 1'b0;
        lane_ready = 1'b0;

        @(negedge arst_n);
        @(posedge arst_n);
        run_cycles(2, 1'b0, 1'b1);
        report_phase("reset state");

        while (!tx_lanes_aligned) begin
            run_cycles(1, 1'b1, 1'b1);
        end
        run_cycles(2 * METALEN, 1'b1, 1'b1);
        report_phase("fill, alignment, data order and sync");

        run_cycles(METALEN, 1'b0, 1'b1);
        report_phase("idle fill");

        run_cycles(2 * FIFO_DEPTH, 1'b1, 1'b0);
        run_cycles(METALEN, 1'b1, 1'b1);
        // drain until every accepted bundle has left
        do begin
            run_cycles(1, 1'b0, 1'b1);
            @(negedge clk_tx_common);
        end while (DUT.chk.q_size != 0);
        report_phase("back-pressure and drain");

        $display("tests run %0d of %0d, assertion failures %0d",
                 phase_cnt, NUM_PHASES, DUT.chk.fail_cnt);
        if (DUT.chk.fail_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    ////////////////////////////////////////
    // run limit
    ////////////////////////////////////////
    always @(posedge clk_tx_common) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire
